/* include/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath and register address widths
`define CORE_XLEN   32
`define CORE_REG_AW 5

// implemented machine CSRs
`define CSR_MSCRATCH 12'h340
`define CSR_MINSTRET 12'hB02

`endif

/* logic/core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

// ---------------------------------------------------------------------------
// instruction encoding
// ---------------------------------------------------------------------------

// only the major opcodes this core understands
typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_SYSTEM = 7'b1110011
} opcode_t;

// register-register layout
typedef struct packed {
    logic [6:0]              funct7;
    logic [`CORE_REG_AW-1:0] rs2;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    opcode_t                 opcode;
} r_fields_t;

// immediate layout, imm12 is also the CSR address
typedef struct packed {
    logic [11:0]             imm12;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [2:0]              funct3;
    logic [`CORE_REG_AW-1:0] rd;
    opcode_t                 opcode;
} i_fields_t;

typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
} inst_t;

// ---------------------------------------------------------------------------
// decoded operation
// ---------------------------------------------------------------------------

typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
} alu_op_t;

typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS
} csr_op_t;

typedef struct packed {
    alu_op_t                 alu_op;
    logic                    use_imm;
    logic [`CORE_XLEN-1:0]   imm;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_REG_AW-1:0] rs1;
    logic [`CORE_REG_AW-1:0] rs2;
    logic                    rd_we;
    csr_op_t                 csr_op;
    logic [11:0]             csr_addr;
    logic                    illegal;
} dec_op_t;

endpackage

/* logic/stage_ifs.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

// ---------------------------------------------------------------------------
// decode -> operand
// ---------------------------------------------------------------------------

interface dec_if;
    // one-cycle strobe, op only meaningful while high
    logic              valid;
    core_pkg::dec_op_t op;

    modport src (
        output valid,
        output op
    );

    modport dst (
        input valid,
        input op
    );
endinterface

// ---------------------------------------------------------------------------
// operand -> execute
// ---------------------------------------------------------------------------

interface exe_if;
    logic                  valid;
    core_pkg::dec_op_t     op;
    // operands after forwarding, b already muxed with the immediate
    logic [`CORE_XLEN-1:0] a_val;
    logic [`CORE_XLEN-1:0] b_val;
    // raw rs1 for CSR writes
    logic [`CORE_XLEN-1:0] rs1_val;

    modport src (
        output valid,
        output op,
        output a_val,
        output b_val,
        output rs1_val
    );

    modport dst (
        input valid,
        input op,
        input a_val,
        input b_val,
        input rs1_val
    );
endinterface

/* logic/inst_decoder.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module inst_decoder (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  core_pkg::inst_t inst,
    dec_if.src              dec
);

core_pkg::dec_op_t op_nxt;
logic [6:0]        funct7;
logic [2:0]        funct3;
logic [11:0]       imm12;
logic              legal;

// r view for the funct fields, i view for the immediate
assign funct7 = inst.r_fields.funct7;
assign funct3 = inst.r_fields.funct3;
assign imm12  = inst.i_fields.imm12;

// ---------------------------------------------------------------------------
// field decode
// ---------------------------------------------------------------------------

always_comb begin
    op_nxt          = '0;
    op_nxt.alu_op   = core_pkg::ALU_ADD;
    op_nxt.csr_op   = core_pkg::CSR_NONE;
    op_nxt.rd       = inst.r_fields.rd;
    op_nxt.rs1      = inst.i_fields.rs1;
    op_nxt.csr_addr = imm12;
    op_nxt.imm      = {{(`CORE_XLEN-12){imm12[11]}}, imm12};
    legal           = 1'b1;
    case (inst.r_fields.opcode)
        core_pkg::OPC_OP: begin
            op_nxt.rs2 = inst.r_fields.rs2;
            if (funct7 == 7'h00) begin
                case (funct3)
                    3'b000:  op_nxt.alu_op = core_pkg::ALU_ADD;
                    3'b010:  op_nxt.alu_op = core_pkg::ALU_SLT;
                    3'b011:  op_nxt.alu_op = core_pkg::ALU_SLTU;
                    3'b100:  op_nxt.alu_op = core_pkg::ALU_XOR;
                    3'b110:  op_nxt.alu_op = core_pkg::ALU_OR;
                    3'b111:  op_nxt.alu_op = core_pkg::ALU_AND;
                    default: legal = 1'b0;
                endcase
            end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
                op_nxt.alu_op = core_pkg::ALU_SUB;
            end else begin
                legal = 1'b0;
            end
        end
        core_pkg::OPC_OP_IMM: begin
            op_nxt.use_imm = 1'b1;
            case (funct3)
                3'b000:  op_nxt.alu_op = core_pkg::ALU_ADD;
                3'b010:  op_nxt.alu_op = core_pkg::ALU_SLT;
                3'b100:  op_nxt.alu_op = core_pkg::ALU_XOR;
                3'b110:  op_nxt.alu_op = core_pkg::ALU_OR;
                3'b111:  op_nxt.alu_op = core_pkg::ALU_AND;
                default: legal = 1'b0;
            endcase
        end
        core_pkg::OPC_LUI: begin
            // upper 20 bits sit where imm12, rs1 and funct3 live
            op_nxt.use_imm = 1'b1;
            op_nxt.alu_op  = core_pkg::ALU_PASS_B;
            op_nxt.rs1     = '0;
            op_nxt.imm     = {imm12, inst.i_fields.rs1, inst.i_fields.funct3, 12'h000};
        end
        core_pkg::OPC_SYSTEM: begin
            if (funct3 == 3'b001 && imm12 == `CSR_MSCRATCH) begin
                op_nxt.csr_op = core_pkg::CSR_RW;
            end else if (funct3 == 3'b010
                         && (imm12 == `CSR_MSCRATCH || imm12 == `CSR_MINSTRET)) begin
                op_nxt.csr_op = core_pkg::CSR_RS;
            end else begin
                legal = 1'b0;
            end
        end
        default: legal = 1'b0;
    endcase
    op_nxt.illegal = !legal;
    op_nxt.rd_we   = legal && (op_nxt.rd != '0);
end

// decoded op register
always_ff @(posedge clk) begin
    if (rst) begin
        dec.valid <= 1'b0;
    end else begin
        dec.valid <= inst_valid;
    end
end

always_ff @(posedge clk) begin
    dec.op <= op_nxt;
end

endmodule

/* logic/operand_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module operand_stage (
    input  logic                    clk,
    input  logic                    rst,
    dec_if.dst                      dec,
    exe_if.src                      exe,
    input  logic                    fwd_we,
    input  logic [`CORE_REG_AW-1:0] fwd_rd,
    input  logic [`CORE_XLEN-1:0]   fwd_data,
    input  logic                    wb_we,
    input  logic [`CORE_REG_AW-1:0] wb_rd,
    input  logic [`CORE_XLEN-1:0]   wb_data
);

localparam int NUM_REGS = 2 ** `CORE_REG_AW;

// x0 has no storage
logic [`CORE_XLEN-1:0] regs [1:NUM_REGS-1];
logic [`CORE_XLEN-1:0] rs1_val;
logic [`CORE_XLEN-1:0] rs2_val;

// ---------------------------------------------------------------------------
// register file
// ---------------------------------------------------------------------------

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (wb_we && wb_rd != '0) begin
        regs[wb_rd] <= wb_data;
    end
end

// execute result wins over writeback, writeback over the array
function automatic logic [`CORE_XLEN-1:0] read_src(
    input logic [`CORE_REG_AW-1:0] addr
);
    logic [`CORE_XLEN-1:0] val;
    if (addr == '0) begin
        val = '0;
    end else if (fwd_we && fwd_rd == addr) begin
        val = fwd_data;
    end else if (wb_we && wb_rd == addr) begin
        val = wb_data;
    end else begin
        val = regs[addr];
    end
    return val;
endfunction

always_comb begin
    rs1_val = read_src(dec.op.rs1);
    rs2_val = read_src(dec.op.rs2);
end

// ---------------------------------------------------------------------------
// DEC/EXE register
// ---------------------------------------------------------------------------

always_ff @(posedge clk) begin
    if (rst) begin
        exe.valid <= 1'b0;
    end else begin
        exe.valid <= dec.valid;
    end
end

always_ff @(posedge clk) begin
    exe.op      <= dec.op;
    exe.a_val   <= rs1_val;
    exe.b_val   <= dec.op.use_imm ? dec.op.imm : rs2_val;
    exe.rs1_val <= rs1_val;
end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    exe_if.dst                      exe,
    output logic                    fwd_we,
    output logic [`CORE_REG_AW-1:0] fwd_rd,
    output logic [`CORE_XLEN-1:0]   fwd_data,
    output logic                    wb_we,
    output logic [`CORE_REG_AW-1:0] wb_rd,
    output logic [`CORE_XLEN-1:0]   wb_data,
    output logic                    retire_illegal
);

logic [`CORE_XLEN-1:0] a;
logic [`CORE_XLEN-1:0] b;
logic [`CORE_XLEN-1:0] alu_res;
logic [`CORE_XLEN-1:0] csr_rdata;
logic [`CORE_XLEN-1:0] csr_wdata;
logic [`CORE_XLEN-1:0] result;
logic [`CORE_XLEN-1:0] mscratch;
logic [`CORE_XLEN-1:0] minstret;
logic                  mscratch_we;

assign a = exe.a_val;
assign b = exe.b_val;

// ---------------------------------------------------------------------------
// ALU
// ---------------------------------------------------------------------------

always_comb begin
    case (exe.op.alu_op)
        core_pkg::ALU_ADD:  alu_res = a + b;
        core_pkg::ALU_SUB:  alu_res = a - b;
        core_pkg::ALU_AND:  alu_res = a & b;
        core_pkg::ALU_OR:   alu_res = a | b;
        core_pkg::ALU_XOR:  alu_res = a ^ b;
        core_pkg::ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        core_pkg::ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, a < b};
        default:            alu_res = b;
    endcase
end

// ---------------------------------------------------------------------------
// CSRs
// ---------------------------------------------------------------------------

// minstret here is the count before this op retires
always_comb begin
    case (exe.op.csr_addr)
        `CSR_MSCRATCH: csr_rdata = mscratch;
        `CSR_MINSTRET: csr_rdata = minstret;
        default:       csr_rdata = '0;
    endcase
end

assign csr_wdata = (exe.op.csr_op == core_pkg::CSR_RW) ? exe.rs1_val
                                                      : (mscratch | exe.rs1_val);

// set-bits with x0 as source is a pure read
assign mscratch_we = exe.valid && !exe.op.illegal
                     && exe.op.csr_addr == `CSR_MSCRATCH
                     && (exe.op.csr_op == core_pkg::CSR_RW
                         || (exe.op.csr_op == core_pkg::CSR_RS && exe.op.rs1 != '0));

always_ff @(posedge clk) begin
    if (rst) begin
        mscratch <= '0;
    end else if (mscratch_we) begin
        mscratch <= csr_wdata;
    end
end

// every retire counts, illegal ones too
always_ff @(posedge clk) begin
    if (rst) begin
        minstret <= '0;
    end else if (exe.valid) begin
        minstret <= minstret + 1'b1;
    end
end

// ---------------------------------------------------------------------------
// result, forwarding and retire
// ---------------------------------------------------------------------------

assign result   = (exe.op.csr_op != core_pkg::CSR_NONE) ? csr_rdata : alu_res;
assign fwd_we   = exe.valid && exe.op.rd_we;
assign fwd_rd   = exe.op.rd;
assign fwd_data = result;

always_ff @(posedge clk) begin
    if (rst) begin
        wb_we <= 1'b0;
    end else begin
        wb_we <= exe.valid;
    end
end

// rd and data read as zero when nothing is written
always_ff @(posedge clk) begin
    wb_rd          <= exe.op.rd_we ? exe.op.rd : '0;
    wb_data        <= exe.op.rd_we ? result : '0;
    retire_illegal <= exe.op.illegal;
end

endmodule

/* logic/mini_core.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module mini_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid,
    input  logic [`CORE_XLEN-1:0]   inst,
    output logic                    retire_valid,
    output logic [`CORE_REG_AW-1:0] retire_rd,
    output logic [`CORE_XLEN-1:0]   retire_data,
    output logic                    retire_illegal
);

dec_if u_dec_if ();
exe_if u_exe_if ();

// combinational bypass from execute
logic                    fwd_we;
logic [`CORE_REG_AW-1:0] fwd_rd;
logic [`CORE_XLEN-1:0]   fwd_data;
// registered writeback, doubles as the retire record
logic                    wb_we;
logic [`CORE_REG_AW-1:0] wb_rd;
logic [`CORE_XLEN-1:0]   wb_data;

inst_decoder u_inst_decoder (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (core_pkg::inst_t'(inst)),
    .dec        (u_dec_if.src)
);

operand_stage u_operand_stage (
    .clk      (clk),
    .rst      (rst),
    .dec      (u_dec_if.dst),
    .exe      (u_exe_if.src),
    .fwd_we   (fwd_we),
    .fwd_rd   (fwd_rd),
    .fwd_data (fwd_data),
    .wb_we    (wb_we),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
);

execute_stage u_execute_stage (
    .clk            (clk),
    .rst            (rst),
    .exe            (u_exe_if.dst),
    .fwd_we         (fwd_we),
    .fwd_rd         (fwd_rd),
    .fwd_data       (fwd_data),
    .wb_we          (wb_we),
    .wb_rd          (wb_rd),
    .wb_data        (wb_data),
    .retire_illegal (retire_illegal)
);

assign retire_valid = wb_we;
assign retire_rd    = wb_rd;
assign retire_data  = wb_data;

endmodule

/* verif/mini_core_tb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module mini_core_tb;

localparam int MAX_TESTS      = 64;
localparam int RETIRE_TIMEOUT = 16;
localparam int QUIET_CYCLES   = 8;

// RV32 major opcodes and funct3 codes
localparam int OPC_R    = 'b0110011;
localparam int OPC_I    = 'b0010011;
localparam int OPC_LUI  = 'b0110111;
localparam int OPC_SYS  = 'b1110011;
localparam int OPC_LOAD = 'b0000011;
localparam int F3_ADD   = 0;
localparam int F3_SLL   = 1;
localparam int F3_SLT   = 2;
localparam int F3_SLTU  = 3;
localparam int F3_XOR   = 4;
localparam int F3_OR    = 6;
localparam int F3_AND   = 7;
localparam int F3_CSRRW = 1;
localparam int F3_CSRRS = 2;

localparam bit GAP   = 1'b0;
localparam bit B2B   = 1'b1;
localparam bit LEGAL = 1'b0;
localparam bit ILL   = 1'b1;

logic                    clk;
logic                    rst;
logic                    inst_valid;
logic [`CORE_XLEN-1:0]   inst;
logic                    retire_valid;
logic [`CORE_REG_AW-1:0] retire_rd;
logic [`CORE_XLEN-1:0]   retire_data;
logic                    retire_illegal;

// stimulus and expected retire record per test
string                   names    [MAX_TESTS];
logic [`CORE_XLEN-1:0]   words    [MAX_TESTS];
int                      gaps     [MAX_TESTS];
logic [`CORE_REG_AW-1:0] exp_rd   [MAX_TESTS];
logic [`CORE_XLEN-1:0]   exp_data [MAX_TESTS];
logic                    exp_ill  [MAX_TESTS];
int                      num_tests;

integer seed;
int     passed_tests;
int     failed_tests;
int     stray_retires;
bit     timed_out;

mini_core u_mini_core (
    .clk            (clk),
    .rst            (rst),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

// ---------------------------------------------------------------------------
// instruction encoders
// ---------------------------------------------------------------------------

function automatic logic [31:0] r_type_word(
    input int funct7,
    input int rs2,
    input int rs1,
    input int funct3,
    input int rd
);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], OPC_R[6:0]};
endfunction

// imm is the CSR address for SYSTEM ops
function automatic logic [31:0] i_type_word(
    input int imm,
    input int rs1,
    input int funct3,
    input int rd,
    input int opcode
);
    return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
endfunction

function automatic logic [31:0] lui_word(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], OPC_LUI[6:0]};
endfunction

task automatic add_test(
    input string       name,
    input logic [31:0] word,
    input bit          back_to_back,
    input int          rd,
    input logic [31:0] data,
    input bit          illegal
);
    names[num_tests]    = name;
    words[num_tests]    = word;
    exp_rd[num_tests]   = rd[4:0];
    exp_data[num_tests] = data;
    exp_ill[num_tests]  = illegal;
    if (back_to_back) begin
        gaps[num_tests] = 0;
    end else begin
        gaps[num_tests] = 1 + ($unsigned($random(seed)) % 3);
    end
    num_tests++;
endtask

// ---------------------------------------------------------------------------
// test table
// ---------------------------------------------------------------------------

task automatic build_table();
    // immediates and LUI
    add_test("addi_x1", i_type_word(5, 0, F3_ADD, 1, OPC_I), GAP, 1, 32'd5, LEGAL);
    add_test("addi_neg", i_type_word(-3, 0, F3_ADD, 2, OPC_I), GAP, 2, 32'hFFFF_FFFD, LEGAL);
    add_test("lui_x3", lui_word('h12345, 3), GAP, 3, 32'h1234_5000, LEGAL);
    add_test("ori_x4", i_type_word('h678, 3, F3_OR, 4, OPC_I), GAP, 4, 32'h1234_5678, LEGAL);
    add_test("andi_x5", i_type_word('h0F0, 4, F3_AND, 5, OPC_I), GAP, 5, 32'h70, LEGAL);
    add_test("xori_not", i_type_word(-1, 1, F3_XOR, 6, OPC_I), GAP, 6, 32'hFFFF_FFFA, LEGAL);
    add_test("slti_neg", i_type_word(0, 2, F3_SLT, 7, OPC_I), GAP, 7, 32'd1, LEGAL);
    add_test("addi_x0", i_type_word(7, 1, F3_ADD, 0, OPC_I), GAP, 0, 32'd0, LEGAL);
    // register-register
    add_test("add", r_type_word(0, 2, 1, F3_ADD, 8), GAP, 8, 32'd2, LEGAL);
    add_test("sub", r_type_word('h20, 2, 1, F3_ADD, 9), GAP, 9, 32'd8, LEGAL);
    add_test("and", r_type_word(0, 6, 4, F3_AND, 10), GAP, 10, 32'h1234_5678, LEGAL);
    add_test("or", r_type_word(0, 3, 1, F3_OR, 11), GAP, 11, 32'h1234_5005, LEGAL);
    add_test("xor", r_type_word(0, 3, 4, F3_XOR, 12), GAP, 12, 32'h678, LEGAL);
    add_test("slt_neg", r_type_word(0, 1, 2, F3_SLT, 13), GAP, 13, 32'd1, LEGAL);
    add_test("sltu_neg", r_type_word(0, 1, 2, F3_SLTU, 13), GAP, 13, 32'd0, LEGAL);
    // dependent chain issued back to back
    add_test("chain_a", i_type_word(100, 0, F3_ADD, 14, OPC_I), GAP, 14, 32'd100, LEGAL);
    add_test("chain_b", i_type_word(1, 14, F3_ADD, 14, OPC_I), B2B, 14, 32'd101, LEGAL);
    add_test("chain_c", r_type_word(0, 14, 14, F3_ADD, 15), B2B, 15, 32'd202, LEGAL);
    add_test("chain_d", r_type_word('h20, 14, 15, F3_ADD, 16), B2B, 16, 32'd101, LEGAL);
    add_test("chain_e", r_type_word(0, 1, 16, F3_ADD, 17), B2B, 17, 32'd106, LEGAL);
    // same chain with idle cycles between
    add_test("spaced_a", i_type_word(100, 0, F3_ADD, 20, OPC_I), GAP, 20, 32'd100, LEGAL);
    add_test("spaced_b", i_type_word(1, 20, F3_ADD, 20, OPC_I), GAP, 20, 32'd101, LEGAL);
    add_test("spaced_c", r_type_word(0, 20, 20, F3_ADD, 21), GAP, 21, 32'd202, LEGAL);
    add_test("spaced_d", r_type_word('h20, 20, 21, F3_ADD, 22), GAP, 22, 32'd101, LEGAL);
    add_test("spaced_e", r_type_word(0, 1, 22, F3_ADD, 23), GAP, 23, 32'd106, LEGAL);
    // mscratch
    add_test("csr_src", i_type_word('h55, 0, F3_ADD, 24, OPC_I), GAP, 24, 32'h55, LEGAL);
    add_test("csrrw", i_type_word(`CSR_MSCRATCH, 24, F3_CSRRW, 25, OPC_SYS), B2B, 25, 32'd0,
             LEGAL);
    add_test("csrrs_set", i_type_word(`CSR_MSCRATCH, 12, F3_CSRRS, 26, OPC_SYS), B2B, 26,
             32'h55, LEGAL);
    add_test("csrrs_x0", i_type_word(`CSR_MSCRATCH, 0, F3_CSRRS, 27, OPC_SYS), GAP, 27,
             32'h67D, LEGAL);
    add_test("csrrs_again", i_type_word(`CSR_MSCRATCH, 0, F3_CSRRS, 28, OPC_SYS), GAP, 28,
             32'h67D, LEGAL);
    // 30 entries ahead of this one
    add_test("minstret_a", i_type_word(`CSR_MINSTRET, 0, F3_CSRRS, 29, OPC_SYS), GAP, 29,
             32'd30, LEGAL);
    // unsupported encodings followed by reads of their rd
    add_test("ill_load", i_type_word(4, 0, 2, 1, OPC_LOAD), GAP, 0, 32'd0, ILL);
    add_test("ill_slli", i_type_word(1, 1, F3_SLL, 2, OPC_I), B2B, 0, 32'd0, ILL);
    add_test("ill_mul", r_type_word(1, 1, 1, F3_ADD, 8), B2B, 0, 32'd0, ILL);
    add_test("keep_x1", i_type_word(0, 1, F3_ADD, 30, OPC_I), B2B, 30, 32'd5, LEGAL);
    add_test("keep_x2", i_type_word(0, 2, F3_ADD, 30, OPC_I), GAP, 30, 32'hFFFF_FFFD, LEGAL);
    add_test("keep_x8", r_type_word(0, 0, 8, F3_ADD, 31), GAP, 31, 32'd2, LEGAL);
    add_test("minstret_b", i_type_word(`CSR_MINSTRET, 0, F3_CSRRS, 29, OPC_SYS), GAP, 29,
             32'd37, LEGAL);
endtask

// ---------------------------------------------------------------------------
// driver and retire monitor
// ---------------------------------------------------------------------------

task automatic drive_table();
    int idx;
    for (idx = 0; idx < num_tests; idx++) begin
        repeat (gaps[idx]) begin
            @(posedge clk);
            #2;
            inst_valid = 1'b0;
        end
        @(posedge clk);
        #2;
        inst_valid = 1'b1;
        inst       = words[idx];
    end
    @(posedge clk);
    #2;
    inst_valid = 1'b0;
endtask

// retire outputs are registered so negedge sees them settled
task automatic watch_retires();
    int idx;
    int wait_cycles;
    int test_errors;
    bit seen;
    for (idx = 0; idx < num_tests && !timed_out; idx++) begin
        seen        = 1'b0;
        wait_cycles = 0;
        while (!seen && wait_cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            if (retire_valid) begin
                seen = 1'b1;
            end else begin
                wait_cycles++;
            end
        end
        if (!seen) begin
            $display("no retire seen for %s within %0d cycles", names[idx], RETIRE_TIMEOUT);
            timed_out = 1'b1;
            failed_tests++;
        end else begin
            test_errors = 0;
            assert (retire_rd == exp_rd[idx]) else begin
                $display("CHECK FAILED %s rd expected %0d actual %0d",
                         names[idx], exp_rd[idx], retire_rd);
                test_errors++;
            end
            assert (retire_data == exp_data[idx]) else begin
                $display("CHECK FAILED %s data expected %08h actual %08h",
                         names[idx], exp_data[idx], retire_data);
                test_errors++;
            end
            assert (retire_illegal == exp_ill[idx]) else begin
                $display("CHECK FAILED %s illegal expected %0b actual %0b",
                         names[idx], exp_ill[idx], retire_illegal);
                test_errors++;
            end
            if (test_errors == 0) begin
                passed_tests++;
                $display("[%0d] %s ok", idx, names[idx]);
            end else begin
                failed_tests++;
                $display("[%0d] %s wrong", idx, names[idx]);
            end
        end
    end
endtask

// nothing may retire once the table is done
task automatic check_quiet();
    repeat (QUIET_CYCLES) begin
        @(negedge clk);
        if (retire_valid) begin
            $display("unexpected retire after the last test, rd %0d", retire_rd);
            stray_retires++;
        end
    end
endtask

initial begin
    seed          = 32'hfc17_0332;
    num_tests     = 0;
    passed_tests  = 0;
    failed_tests  = 0;
    stray_retires = 0;
    timed_out     = 1'b0;
    rst           = 1'b1;
    inst_valid    = 1'b0;
    inst          = '0;
    build_table();

    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    fork
        drive_table();
        watch_retires();
    join
    check_quiet();

    $display("tests %0d, passed %0d, failed %0d, stray retires %0d",
             num_tests, passed_tests, failed_tests, stray_retires);
    if (failed_tests == 0 && passed_tests == num_tests && stray_retires == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule

/* list.f */
+incdir+include
logic/core_pkg.sv
logic/stage_ifs.sv
logic/inst_decoder.sv
logic/operand_stage.sv
logic/execute_stage.sv
logic/mini_core.sv
verif/mini_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mini_core_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build did not complete"
    exit 1
fi

output=$(./obj_dir/Vmini_core_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$output" | grep -qx "sim passed"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0
